//--- Bender.yml
package:
  name: uncore_mem

sources:
  - source/uncore_pkg.sv
  - source/flush_sequencer.sv
  - source/mem_req_queue.sv
  - source/mem_port.sv
  - source/uncore_mem_top.sv
  - target: simulation
    files:
      - verif/uncore_assert.sv
      - verif/uncore_tb.sv

//--- all.f
source/uncore_pkg.sv
source/flush_sequencer.sv
source/mem_req_queue.sv
source/mem_port.sv
source/uncore_mem_top.sv
verif/uncore_assert.sv
verif/uncore_tb.sv

//--- source/flush_sequencer.sv
`timescale 1ns/1ps

module flush_sequencer
(
   input  logic                  clk,
   input  logic                  reset,
   input  uncore_pkg::l1_flush_t l1_flush_req,
   input  uncore_pkg::l1_flush_t l1_flush_done,
   input  logic                  l2_flush_done,
   output logic                  l2_flush,
   output logic                  in_flush_mode
);

   uncore_pkg::flush_state_t state;
   uncore_pkg::flush_state_t next_state;
   uncore_pkg::l1_flush_t    owed;
   uncore_pkg::l1_flush_t    remaining;
   logic                     next_l2_flush;

   // wait state for a set of caches still to finish
   function automatic uncore_pkg::flush_state_t wait_state
   (
      input uncore_pkg::l1_flush_t pending
   );
      uncore_pkg::flush_state_t s;
      case ({pending.icache, pending.dcache})
         2'b11:
         begin
            s = uncore_pkg::WAIT_BOTH;
         end
         2'b10:
         begin
            s = uncore_pkg::WAIT_ICACHE;
         end
         2'b01:
         begin
            s = uncore_pkg::WAIT_DCACHE;
         end
         default:
         begin
            s = uncore_pkg::FLUSH_L2;
         end
      endcase
      return s;
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= uncore_pkg::FLUSH_IDLE;
         l2_flush <= 1'b0;
      end
      else
      begin
         state    <= next_state;
         l2_flush <= next_l2_flush;
      end
   end

   assign in_flush_mode = (state != uncore_pkg::FLUSH_IDLE);

   // caches owing completion, decoded from state
   always_comb
   begin
      owed.icache = (state == uncore_pkg::WAIT_BOTH) || (state == uncore_pkg::WAIT_ICACHE);
      owed.dcache = (state == uncore_pkg::WAIT_BOTH) || (state == uncore_pkg::WAIT_DCACHE);
      remaining = owed & ~l1_flush_done;
   end

   always_comb
   begin
      next_state    = state;
      next_l2_flush = 1'b0;
      case (state)
         uncore_pkg::FLUSH_IDLE:
         begin
            // a cache left out of the request counts as done
            if (l1_flush_req != '0)
            begin
               next_state = wait_state(l1_flush_req);
            end
         end
         uncore_pkg::WAIT_BOTH,
         uncore_pkg::WAIT_ICACHE,
         uncore_pkg::WAIT_DCACHE:
         begin
            next_state    = wait_state(remaining);
            next_l2_flush = (remaining == '0);
         end
         uncore_pkg::FLUSH_L2:
         begin
            if (l2_flush_done)
            begin
               next_state = uncore_pkg::FLUSH_IDLE;
            end
         end
         default:
         begin
            next_state = uncore_pkg::FLUSH_IDLE;
         end
      endcase
   end

endmodule

//--- source/mem_port.sv
`timescale 1ns/1ps

module mem_port
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  l2_req_valid,
   input  uncore_pkg::mem_req_t  l2_req,
   output logic                  l2_req_ready,
   output logic                  mem_req_valid,
   output uncore_pkg::mem_req_t  mem_req,
   input  logic                  mem_req_gnt,
   input  logic                  mem_rsp_valid,
   output uncore_pkg::inflight_t inflight
);

   logic push_accept;

   mem_req_queue queue
   (
      .clk        (clk),
      .reset      (reset),
      .push_valid (l2_req_valid),
      .push_req   (l2_req),
      .push_ready (l2_req_ready),
      .pop_valid  (mem_req_valid),
      .pop_req    (mem_req),
      .pop_gnt    (mem_req_gnt)
   );

   assign push_accept = l2_req_valid && l2_req_ready;

   // up on accepted push, down on response, unchanged when both
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         inflight <= '0;
      end
      else if (push_accept && !mem_rsp_valid)
      begin
         inflight <= inflight + 1'b1;
      end
      else if (!push_accept && mem_rsp_valid)
      begin
         inflight <= inflight - 1'b1;
      end
   end

endmodule

//--- source/mem_req_queue.sv
`timescale 1ns/1ps

module mem_req_queue
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 push_valid,
   input  uncore_pkg::mem_req_t push_req,
   output logic                 push_ready,
   output logic                 pop_valid,
   output uncore_pkg::mem_req_t pop_req,
   input  logic                 pop_gnt
);

   localparam int LG = uncore_pkg::LG_QUEUE_DEPTH;

   // payload storage
   uncore_pkg::mem_req_t entries [uncore_pkg::QUEUE_DEPTH];

   // pointers carry a wrap bit above the index
   logic [LG:0] head;
   logic [LG:0] tail;
   logic [LG:0] next_head;
   logic [LG:0] next_tail;

   logic empty;
   logic full;
   logic push;
   logic pop;

   assign empty = (head == tail);
   assign full  = (head[LG-1:0] == tail[LG-1:0]) && (head[LG] != tail[LG]);

   assign push_ready = !full;
   assign pop_valid  = !empty;

   assign push = push_valid && push_ready;
   assign pop  = pop_valid && pop_gnt;

   // head entry straight out of the array
   assign pop_req = entries[head[LG-1:0]];

   always_comb
   begin
      next_head = head;
      next_tail = tail;
      if (push)
      begin
         next_tail = tail + 1'b1;
      end
      if (pop)
      begin
         next_head = head + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         head <= '0;
         tail <= '0;
      end
      else
      begin
         head <= next_head;
         tail <= next_tail;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         entries[tail[LG-1:0]] <= push_req;
      end
   end

endmodule

//--- source/uncore_mem_top.sv
`timescale 1ns/1ps

module uncore_mem_top
(
   input  logic                  clk,
   input  logic                  reset,

   // flush side
   input  uncore_pkg::l1_flush_t l1_flush_req,
   input  uncore_pkg::l1_flush_t l1_flush_done,
   input  logic                  l2_flush_done,
   output logic                  l2_flush,
   output logic                  in_flush_mode,

   // requests from the L2
   input  logic                  l2_req_valid,
   input  uncore_pkg::mem_req_t  l2_req,
   output logic                  l2_req_ready,

   // external memory
   output logic                  mem_req_valid,
   output uncore_pkg::mem_req_t  mem_req,
   input  logic                  mem_req_gnt,
   input  logic                  mem_rsp_valid,
   output uncore_pkg::inflight_t inflight
);

   flush_sequencer flush_seq
   (
      .clk           (clk),
      .reset         (reset),
      .l1_flush_req  (l1_flush_req),
      .l1_flush_done (l1_flush_done),
      .l2_flush_done (l2_flush_done),
      .l2_flush      (l2_flush),
      .in_flush_mode (in_flush_mode)
   );

   mem_port port
   (
      .clk           (clk),
      .reset         (reset),
      .l2_req_valid  (l2_req_valid),
      .l2_req        (l2_req),
      .l2_req_ready  (l2_req_ready),
      .mem_req_valid (mem_req_valid),
      .mem_req       (mem_req),
      .mem_req_gnt   (mem_req_gnt),
      .mem_rsp_valid (mem_rsp_valid),
      .inflight      (inflight)
   );

endmodule

//--- source/uncore_pkg.sv
package uncore_pkg;

   // memory side widths
   localparam int PA_WIDTH = 32;
   localparam int LG_REQ_TAGS = 2;
   localparam int CL_BITS = 128;
   localparam int OPCODE_WIDTH = 4;

   // one more entry bit than tags so every tag can be queued twice over
   localparam int LG_QUEUE_DEPTH = LG_REQ_TAGS + 1;
   localparam int QUEUE_DEPTH = 1 << LG_QUEUE_DEPTH;

   // one cache line request toward external memory
   typedef struct packed {
      logic [PA_WIDTH-1:0]     addr;
      logic [LG_REQ_TAGS-1:0]  tag;
      logic [CL_BITS-1:0]      data;
      logic [OPCODE_WIDTH-1:0] opcode;
   } mem_req_t;

   // per L1 cache flag, used for requests and for completions
   typedef struct packed {
      logic icache;
      logic dcache;
   } l1_flush_t;

   // wait states name the caches that still owe a completion
   typedef enum logic [2:0] {
      FLUSH_IDLE  = 3'd0,
      WAIT_BOTH   = 3'd1,
      WAIT_ICACHE = 3'd2,
      WAIT_DCACHE = 3'd3,
      FLUSH_L2    = 3'd4
   } flush_state_t;

   // accepted requests still waiting for a response
   typedef logic [LG_QUEUE_DEPTH:0] inflight_t;

endpackage

//--- verif/uncore_assert.sv
`timescale 1ns/1ps

module uncore_assert
(
   input logic                  clk,
   input logic                  reset,
   input logic                  l2_flush,
   input logic                  in_flush_mode,
   input logic                  l2_req_valid,
   input logic                  l2_req_ready,
   input logic                  mem_req_valid,
   input uncore_pkg::mem_req_t  mem_req,
   input logic                  mem_req_gnt,
   input logic                  mem_rsp_valid,
   input uncore_pkg::inflight_t inflight
);

   // flush command only inside flush mode
   flush_in_mode: assert property (@(posedge clk) disable iff (reset)
      l2_flush |-> in_flush_mode)
      else $error("l2_flush high outside flush mode");

   // head held while memory withholds the grant
   head_stable: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid && !mem_req_gnt |=> $stable(mem_req))
      else $error("mem_req changed while waiting for grant");

   // refused push leaves the count alone unless a response lands
   no_push_when_full: assert property (@(posedge clk) disable iff (reset)
      l2_req_valid && !l2_req_ready && !mem_rsp_valid |=> inflight == $past(inflight))
      else $error("request accepted while l2_req_ready low");

   flush_one_cycle: assert property (@(posedge clk) disable iff (reset)
      l2_flush |=> !l2_flush)
      else $error("l2_flush longer than one cycle");

endmodule

bind uncore_mem_top uncore_assert checks (.*);

//--- verif/uncore_tb.sv
`timescale 1ns/1ps

module uncore_tb;

   localparam int REQ_ROWS = 24;
   localparam int FLUSH_ROWS = 5;
   localparam int CYCLE_LIMIT = (REQ_ROWS + FLUSH_ROWS) * 40 + 200;

   typedef struct {
      uncore_pkg::l1_flush_t req;
      uncore_pkg::l1_flush_t done_a;
      int                    gap_a;
      uncore_pkg::l1_flush_t done_b;
      int                    gap_b;
      uncore_pkg::l1_flush_t stray;
      int                    l2_delay;
      logic                  expect_flush;
   } flush_row_t;

   typedef struct {
      uncore_pkg::mem_req_t req;
      int                   rsp_delay;
   } req_row_t;

   logic                  clk;
   logic                  reset;
   uncore_pkg::l1_flush_t l1_flush_req;
   uncore_pkg::l1_flush_t l1_flush_done;
   logic                  l2_flush_done;
   logic                  l2_flush;
   logic                  in_flush_mode;
   logic                  l2_req_valid;
   uncore_pkg::mem_req_t  l2_req;
   logic                  l2_req_ready;
   logic                  mem_req_valid;
   uncore_pkg::mem_req_t  mem_req;
   logic                  mem_req_gnt;
   logic                  mem_rsp_valid;
   uncore_pkg::inflight_t inflight;

   flush_row_t flush_table [FLUSH_ROWS];
   req_row_t   req_table [REQ_ROWS];

   // memory side reference model
   uncore_pkg::mem_req_t exp_q [$];
   int                   delay_q [$];
   int                   rsp_timer [$];
   int                   req_delay;
   logic                 hold_gnt;
   int                   acc_total;
   int                   rsp_total;
   int                   both_count;
   int                   cycle_count;
   logic                 exp_ready;
   logic                 pushed;
   logic                 popped;
   logic                 fire;
   int                   pop_delay;
   int                   idx;
   logic [31:0]          bits;

   uncore_mem_top dut (.*);

   always #4 clk = ~clk;

   task automatic fail_run();
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_count(input string name, input uncore_pkg::inflight_t exp,
                              input uncore_pkg::inflight_t act);
      if (act !== exp)
      begin
         $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_req(input string name, input uncore_pkg::mem_req_t exp,
                            input uncore_pkg::mem_req_t act);
      if (act !== exp)
      begin
         $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
         fail_run();
      end
   endtask

   function automatic uncore_pkg::mem_req_t random_req();
      uncore_pkg::mem_req_t r;
      logic [31:0]          t;
      t = $urandom;
      r.addr = $urandom;
      r.tag = t[1:0];
      r.opcode = t[7:4];
      r.data = {$urandom, $urandom, $urandom, $urandom};
      return r;
   endfunction

   // one clock and a check of the flush outputs from the cycle just ended
   task automatic cycle_check(input logic exp_mode, input logic exp_flush);
      @(posedge clk);
      check_bit("in_flush_mode", exp_mode, in_flush_mode);
      check_bit("l2_flush", exp_flush, l2_flush);
   endtask

   task automatic run_flush_row(input flush_row_t row);
      uncore_pkg::l1_flush_t owed;
      logic                  active;
      owed = row.req;
      active = row.expect_flush;
      l1_flush_req <= row.req;
      cycle_check(1'b0, 1'b0);
      l1_flush_req <= '0;
      repeat (row.gap_a) cycle_check(active, 1'b0);
      // stray request lands mid-flush and must be ignored
      l1_flush_done <= row.done_a;
      l1_flush_req  <= row.stray;
      cycle_check(active, 1'b0);
      l1_flush_done <= '0;
      l1_flush_req  <= '0;
      owed = owed & ~row.done_a;
      if (owed != '0)
      begin
         repeat (row.gap_b) cycle_check(active, 1'b0);
         l1_flush_done <= row.done_b;
         cycle_check(active, 1'b0);
         l1_flush_done <= '0;
      end
      if (active)
      begin
         cycle_check(1'b1, 1'b1);
         repeat (row.l2_delay) cycle_check(1'b1, 1'b0);
         l2_flush_done <= 1'b1;
         cycle_check(1'b1, 1'b0);
         l2_flush_done <= 1'b0;
      end
      cycle_check(1'b0, 1'b0);
   endtask

   task automatic push_request(input req_row_t row);
      // keep outstanding requests within queue depth
      @(negedge clk);
      while (acc_total - rsp_total >= uncore_pkg::QUEUE_DEPTH)
         @(negedge clk);
      @(posedge clk);
      l2_req_valid <= 1'b1;
      l2_req       <= row.req;
      req_delay    <= row.rsp_delay;
      @(posedge clk);
      while (!l2_req_ready)
         @(posedge clk);
      l2_req_valid <= 1'b0;
   endtask

   task automatic wait_quiet();
      @(negedge clk);
      while (exp_q.size() != 0 || rsp_timer.size() != 0 || mem_rsp_valid)
         @(negedge clk);
      check_count("inflight", uncore_pkg::inflight_t'(acc_total - rsp_total), inflight);
   endtask

   task automatic fill_with_grant_low();
      int accepted;
      accepted = 0;
      @(posedge clk);
      hold_gnt <= 1'b1;
      repeat (2) @(posedge clk);
      repeat (uncore_pkg::QUEUE_DEPTH + 4)
      begin
         l2_req_valid <= 1'b1;
         l2_req       <= random_req();
         req_delay    <= 3;
         @(posedge clk);
         // push taken by the DUT at this edge
         if (l2_req_ready)
            accepted = accepted + 1;
      end
      l2_req_valid <= 1'b0;
      hold_gnt     <= 1'b0;
      @(negedge clk);
      check_count("accepted pushes", uncore_pkg::inflight_t'(uncore_pkg::QUEUE_DEPTH),
                  uncore_pkg::inflight_t'(accepted));
      check_bit("l2_req_ready", 1'b0, l2_req_ready);
   endtask

   // checks the memory side each edge and plays memory
   always @(posedge clk)
   begin
      if (reset)
      begin
         mem_req_gnt   <= 1'b0;
         mem_rsp_valid <= 1'b0;
      end
      else
      begin
         exp_ready = (exp_q.size() < uncore_pkg::QUEUE_DEPTH);
         check_bit("l2_req_ready", exp_ready, l2_req_ready);
         check_bit("mem_req_valid", exp_q.size() != 0, mem_req_valid);
         check_count("inflight", uncore_pkg::inflight_t'(acc_total - rsp_total), inflight);
         if (exp_q.size() != 0)
            check_req("mem_req", exp_q[0], mem_req);
         pushed = l2_req_valid && exp_ready;
         popped = (exp_q.size() != 0) && mem_req_gnt;
         if (pushed && mem_rsp_valid)
            both_count = both_count + 1;
         if (mem_rsp_valid)
            rsp_total = rsp_total + 1;
         if (popped)
         begin
            void'(exp_q.pop_front());
            pop_delay = delay_q.pop_front();
         end
         if (pushed)
         begin
            exp_q.push_back(l2_req);
            delay_q.push_back(req_delay);
            acc_total = acc_total + 1;
         end
         // at most one response per cycle so the first expired timer wins
         fire = 1'b0;
         idx = -1;
         foreach (rsp_timer[i])
         begin
            if (rsp_timer[i] > 0)
               rsp_timer[i] = rsp_timer[i] - 1;
            if (rsp_timer[i] == 0 && idx < 0)
               idx = i;
         end
         if (idx >= 0)
         begin
            rsp_timer.delete(idx);
            fire = 1'b1;
         end
         if (popped)
            rsp_timer.push_back(pop_delay);
         bits = $urandom;
         mem_rsp_valid <= fire;
         mem_req_gnt   <= hold_gnt ? 1'b0 : bits[0];
      end
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("timeout: test still running after %0d cycles", cycle_count);
         fail_run();
      end
   end

   initial
   begin
      logic [31:0] r;
      void'($urandom(19));
      clk = 1'b0;
      reset = 1'b1;
      l1_flush_req = '0;
      l1_flush_done = '0;
      l2_flush_done = 1'b0;
      l2_req_valid = 1'b0;
      l2_req = '0;
      mem_req_gnt = 1'b0;
      mem_rsp_valid = 1'b0;
      req_delay = 1;
      hold_gnt = 1'b0;
      acc_total = 0;
      rsp_total = 0;
      both_count = 0;
      cycle_count = 0;
      for (int i = 0; i < REQ_ROWS; i++)
      begin
         r = $urandom;
         req_table[i].req = random_req();
         req_table[i].rsp_delay = 1 + int'(r[2:0]);
      end
      // req, done_a, gap_a, done_b, gap_b, stray, l2 delay, l2_flush expected
      flush_table[0] = '{2'b11, 2'b10, 3, 2'b01, 4, 2'b00, 3, 1'b1};
      flush_table[1] = '{2'b11, 2'b01, 2, 2'b10, 1, 2'b00, 0, 1'b1};
      flush_table[2] = '{2'b01, 2'b01, 2, 2'b00, 0, 2'b10, 2, 1'b1};
      flush_table[3] = '{2'b01, 2'b01, 4, 2'b00, 0, 2'b11, 1, 1'b1};
      flush_table[4] = '{2'b00, 2'b11, 2, 2'b00, 0, 2'b00, 0, 1'b0};
      repeat (2) @(posedge clk);
      check_bit("l2_flush", 1'b0, l2_flush);
      check_bit("in_flush_mode", 1'b0, in_flush_mode);
      check_bit("mem_req_valid", 1'b0, mem_req_valid);
      check_bit("l2_req_ready", 1'b1, l2_req_ready);
      check_count("inflight", '0, inflight);
      reset <= 1'b0;
      for (int i = 0; i < FLUSH_ROWS; i++)
         run_flush_row(flush_table[i]);
      for (int i = 0; i < REQ_ROWS; i++)
         push_request(req_table[i]);
      wait_quiet();
      fill_with_grant_low();
      wait_quiet();
      if (both_count > 0)
      begin
         $display("=== PASS ===");
         $finish;
      end
      else
      begin
         $display("no cycle had an accepted push and a response together");
         fail_run();
      end
   end

endmodule
